// ==== logic/array_multiplier.sv ====
`timescale 1ns/1ps

module array_multiplier (
	input  logic              clk,
	input  logic              arst_n,

	input  logic              in_valid,
	output logic              in_ready,
	input  mul_pkg::mul_req_t in_data,

	output logic              out_valid,
	input  logic              out_ready,
	output mul_pkg::product_t out_data
);

	import mul_pkg::*;

	// Link s feeds stage s, link NUM_STAGES feeds the FIFO
	csa_row_t              stage_data [NUM_STAGES+1];
	logic [NUM_STAGES:0]   stage_valid;
	logic [NUM_STAGES:0]   stage_ready;

	csa_row_t fifo_data;
	logic     fifo_valid;
	logic     fifo_ready;

	// Empty array state for a new operand pair
	assign stage_data[0] = '{a: in_data.a, b: in_data.b, sum: '0, carry: '0, low: '0};
	assign stage_valid[0] = in_valid;
	assign in_ready = stage_ready[0];

	//////////////////////////////////////////////////////////////////////
	// Carry-save array
	//////////////////////////////////////////////////////////////////////

	for (genvar s = 0; s < NUM_STAGES; s++) begin : g_stage
		array_row_stage #(
			.FIRST_ROW (s * ROWS_PER_STAGE)
		) stage_i (
			.clk       (clk),
			.arst_n    (arst_n),
			.in_valid  (stage_valid[s]),
			.in_ready  (stage_ready[s]),
			.in_data   (stage_data[s]),
			.out_valid (stage_valid[s+1]),
			.out_ready (stage_ready[s+1]),
			.out_data  (stage_data[s+1])
		);
	end

	partial_fifo fifo_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (stage_valid[NUM_STAGES]),
		.in_ready  (stage_ready[NUM_STAGES]),
		.in_data   (stage_data[NUM_STAGES]),
		.out_valid (fifo_valid),
		.out_ready (fifo_ready),
		.out_data  (fifo_data)
	);

	merge_adder merge_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (fifo_valid),
		.in_ready  (fifo_ready),
		.in_data   (fifo_data),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data)
	);

endmodule

// ==== logic/array_row_stage.sv ====
`timescale 1ns/1ps

module array_row_stage #(
	parameter int FIRST_ROW = 0
) (
	input  logic              clk,
	input  logic              arst_n,

	input  logic              in_valid,
	output logic              in_ready,
	input  mul_pkg::csa_row_t in_data,

	output logic              out_valid,
	input  logic              out_ready,
	output mul_pkg::csa_row_t out_data
);

	import mul_pkg::*;

	csa_row_t row_nxt;
	logic     in_fire;

	//////////////////////////////////////////////////////////////////////
	// Carry-save rows
	//////////////////////////////////////////////////////////////////////

	// Each row is one line of AND-gated full adders.
	// Sum moves one column down, carry stays in its column.
	always_comb begin : rows
		operand_t sum_in;
		operand_t pp;
		operand_t cy;

		row_nxt = in_data;
		for (int k = 0; k < ROWS_PER_STAGE; k++) begin
			sum_in = {1'b0, row_nxt.sum[OPERAND_W-1:1]};
			pp = row_nxt.a & {OPERAND_W{row_nxt.b[FIRST_ROW + k]}};
			cy = (sum_in & pp) | (pp & row_nxt.carry) | (sum_in & row_nxt.carry);
			row_nxt.sum = sum_in ^ pp ^ row_nxt.carry;
			row_nxt.carry = cy;
			// Column 0 is final once its row is done
			row_nxt.low[FIRST_ROW + k] = row_nxt.sum[0];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Pipeline register
	//////////////////////////////////////////////////////////////////////

	assign in_ready = !out_valid || out_ready;
	assign in_fire = in_valid && in_ready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_fire) begin
			out_data <= row_nxt;
		end
	end

	// Stalled output holds both valid and payload
	a_hold_while_stalled: assert property (
		@(posedge clk) disable iff (!arst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_data)
	) else $error("row stage %0d changed a stalled output", FIRST_ROW);

endmodule

// ==== logic/merge_adder.sv ====
`timescale 1ns/1ps

module merge_adder (
	input  logic              clk,
	input  logic              arst_n,

	input  logic              in_valid,
	output logic              in_ready,
	input  mul_pkg::csa_row_t in_data,

	output logic              out_valid,
	input  logic              out_ready,
	output mul_pkg::product_t out_data
);

	import mul_pkg::*;

	product_t product_nxt;

	//////////////////////////////////////////////////////////////////////
	// Final ripple row
	//////////////////////////////////////////////////////////////////////

	// Shifted sums plus carries, one column at a time
	always_comb begin : ripple
		operand_t sum_in;
		operand_t upper;
		logic     c;

		sum_in = {1'b0, in_data.sum[OPERAND_W-1:1]};
		c = 1'b0;
		for (int j = 0; j < OPERAND_W; j++) begin
			upper[j] = sum_in[j] ^ in_data.carry[j] ^ c;
			c = (sum_in[j] & in_data.carry[j]) | (sum_in[j] & c) | (in_data.carry[j] & c);
		end
		product_nxt = {upper, in_data.low};
	end

	//////////////////////////////////////////////////////////////////////
	// Output register
	//////////////////////////////////////////////////////////////////////

	assign in_ready = !out_valid || out_ready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			out_data <= product_nxt;
		end
	end

	a_hold_while_stalled: assert property (
		@(posedge clk) disable iff (!arst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_data)
	) else $error("merge adder changed a stalled product");

endmodule

// ==== logic/mul_pkg.sv ====
package mul_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths and pipeline shape
	//////////////////////////////////////////////////////////////////////

	localparam int OPERAND_W = 16;
	localparam int PRODUCT_W = 2 * OPERAND_W;

	// Array rows folded into one clocked stage
	localparam int ROWS_PER_STAGE = 4;
	localparam int NUM_STAGES = OPERAND_W / ROWS_PER_STAGE;

	// Partial result buffer in front of the merge adder
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

	//////////////////////////////////////////////////////////////////////
	// Payload types
	//////////////////////////////////////////////////////////////////////

	typedef logic [OPERAND_W-1:0] operand_t;
	typedef logic [PRODUCT_W-1:0] product_t;

	typedef struct packed {
		operand_t a;
		operand_t b;
	} mul_req_t;

	// Array state between rows
	// sum[j] of row i weighs 2^(i+j), carry[j] weighs 2^(i+j+1)
	typedef struct packed {
		operand_t a;
		operand_t b;
		operand_t sum;
		operand_t carry;
		operand_t low;
	} csa_row_t;

endpackage

// ==== logic/partial_fifo.sv ====
`timescale 1ns/1ps

module partial_fifo (
	input  logic              clk,
	input  logic              arst_n,

	input  logic              in_valid,
	output logic              in_ready,
	input  mul_pkg::csa_row_t in_data,

	output logic              out_valid,
	input  logic              out_ready,
	output mul_pkg::csa_row_t out_data
);

	import mul_pkg::*;

	csa_row_t mem [FIFO_DEPTH];

	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_CNT_W-1:0] count;
	logic                  wr_en;
	logic                  rd_en;

	function automatic logic [FIFO_PTR_W-1:0] ptr_inc(input logic [FIFO_PTR_W-1:0] ptr);
		if (ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// Full FIFO still takes data when an entry leaves this cycle
	assign out_valid = count != '0;
	assign in_ready = (count != FIFO_CNT_W'(FIFO_DEPTH)) || out_ready;
	assign wr_en = in_valid && in_ready;
	assign rd_en = out_valid && out_ready;
	assign out_data = mem[rd_ptr];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (rd_en) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			case ({wr_en, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= in_data;
		end
	end

	a_count_bound: assert property (
		@(posedge clk) disable iff (!arst_n)
		count <= FIFO_CNT_W'(FIFO_DEPTH)
	) else $error("partial FIFO count overflow");

	// Empty FIFO never advances its read side
	a_no_empty_read: assert property (
		@(posedge clk) disable iff (!arst_n)
		count == '0 |=> rd_ptr == $past(rd_ptr)
	) else $error("partial FIFO read while empty");

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the array multiplier testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module array_multiplier_tb -f sim.f -o array_multiplier_sim &&
./obj_dir/array_multiplier_sim | tee /dev/stderr | grep -qx "Testbench passed" &&
echo "Simulation OK" ||
{ echo "Simulation FAILED"; exit 1; }

// ==== sim.f ====
logic/mul_pkg.sv
logic/array_row_stage.sv
logic/partial_fifo.sv
logic/merge_adder.sv
logic/array_multiplier.sv
verification/array_multiplier_tb.sv

// ==== verification/array_multiplier_tb.sv ====
`timescale 1ns/1ps

module array_multiplier_tb;

	import mul_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 16;
	localparam logic [31:0] SEED = 32'ha79da4f0;

	localparam int NUM_CORNER = 7 + 2 * OPERAND_W;
	localparam int NUM_STREAM = 500;
	localparam int NUM_STALL = 300;
	localparam int NUM_CAPACITY = 12;
	localparam int NUM_TXN = NUM_CORNER + NUM_STREAM + NUM_STALL + NUM_CAPACITY;
	localparam int WATCHDOG_CYCLES = NUM_TXN * 40;

	// Stall probabilities in percent
	localparam int IN_GAP_PCT = 25;
	localparam int OUT_STALL_PCT = 30;

	// Items held by the stages, the FIFO entries and the merge register
	localparam int MAX_HELD = NUM_STAGES + FIFO_DEPTH + 1;

	typedef struct packed {
		mul_req_t req;
		product_t prod;
	} expect_t;

	logic     clk = 1'b0;
	logic     arst_n;
	logic     in_valid;
	logic     in_ready;
	mul_req_t in_data;
	logic     out_valid;
	logic     out_ready;
	product_t out_data;

	expect_t expected_q [$];
	int      n_in = 0;
	int      n_out = 0;
	int      out_stall_pct = 0;

	array_multiplier array_multiplier_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (in_data),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Reference model and helpers
	//////////////////////////////////////////////////////////////////////

	// Shift and add over the multiplier bits
	function automatic product_t ref_mul(input operand_t a, input operand_t b);
		product_t acc;
		acc = '0;
		for (int i = 0; i < OPERAND_W; i++) begin
			if (b[i]) begin
				acc = acc + (product_t'(a) << i);
			end
		end
		return acc;
	endfunction

	task automatic stop_with_error(input string what);
		$display("%s", what);
		$display("Testbench failed");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	// Called right after a rising edge, returns after the transfer edge
	task automatic send_req(input operand_t a, input operand_t b);
		in_valid <= 1'b1;
		in_data <= '{a: a, b: b};
		do begin
			@(posedge clk);
		end while (!in_ready);
		in_valid <= 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic wait_drain();
		do begin
			@(posedge clk);
		end while (expected_q.size() != 0);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequences
	//////////////////////////////////////////////////////////////////////

	task automatic check_reset();
		int waited;
		waited = 0;
		@(posedge clk);
		assert (!out_valid)
		else stop_with_error($sformatf("CHECK FAILED at %0t: out_valid high after reset",
			$time));
		while (!in_ready && waited < 4) begin
			@(posedge clk);
			waited++;
		end
		assert (in_ready)
		else stop_with_error($sformatf("CHECK FAILED at %0t: in_ready low after reset",
			$time));
	endtask

	task automatic send_corners();
		send_req('0, '0);
		send_req('0, 16'hFFFF);
		send_req(16'hFFFF, '0);
		send_req(16'd1, 16'd1);
		send_req(16'd1, 16'hFFFF);
		send_req(16'hFFFF, 16'd1);
		send_req(16'hFFFF, 16'hFFFF);
		for (int i = 0; i < OPERAND_W; i++) begin
			send_req(operand_t'(1) << i, operand_t'(1) << (OPERAND_W - 1 - i));
			send_req(operand_t'(1) << i, 16'hFFFF);
		end
		wait_drain();
	endtask

	task automatic stream_random(input int n);
		out_stall_pct = 0;
		for (int i = 0; i < n; i++) begin
			send_req(operand_t'($urandom), operand_t'($urandom));
		end
		wait_drain();
	endtask

	task automatic stall_random(input int n);
		out_stall_pct = OUT_STALL_PCT;
		for (int i = 0; i < n; i++) begin
			if ($urandom_range(99) < IN_GAP_PCT) begin
				idle_cycles($urandom_range(3, 1));
			end
			send_req(operand_t'($urandom), operand_t'($urandom));
		end
		wait_drain();
		out_stall_pct = 0;
	endtask

	// Fill the multiplier against a blocked output, then let it drain
	task automatic check_capacity();
		int accepted;
		int quiet;
		accepted = 0;
		quiet = 0;
		out_stall_pct = 100;
		idle_cycles(2);
		in_valid <= 1'b1;
		in_data <= '{a: operand_t'($urandom), b: operand_t'($urandom)};
		while (quiet < 20 && accepted < NUM_CAPACITY) begin
			@(posedge clk);
			if (in_ready) begin
				accepted++;
				quiet = 0;
				in_data <= '{a: operand_t'($urandom), b: operand_t'($urandom)};
			end else begin
				quiet++;
			end
		end
		assert (accepted <= MAX_HELD)
		else stop_with_error($sformatf("CHECK FAILED at %0t: %0d requests taken while blocked",
			$time, accepted));
		out_stall_pct = 0;
		do begin
			@(posedge clk);
		end while (!in_ready);
		in_valid <= 1'b0;
		wait_drain();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Monitors
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (arst_n) begin
			out_ready <= ($urandom_range(99) >= out_stall_pct);
		end
	end

	always @(posedge clk) begin
		if (arst_n && in_valid && in_ready) begin
			expected_q.push_back('{req: in_data, prod: ref_mul(in_data.a, in_data.b)});
			n_in++;
		end
	end

	always @(posedge clk) begin : compare
		expect_t want;
		if (arst_n && out_valid && out_ready) begin
			assert (expected_q.size() != 0)
			else stop_with_error("A product came out with no request outstanding");
			want = expected_q.pop_front();
			assert (out_data == want.prod)
			else stop_with_error($sformatf("CHECK FAILED at %0t: %h * %h gave %h, expected %h",
				$time, want.req.a, want.req.b, out_data, want.prod));
			n_out++;
		end
	end

	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		stop_with_error("The run timed out before all transactions completed");
	end

	initial begin : main
		void'($urandom(SEED));
		$timeformat(-9, 0, " ns", 0);
		arst_n = 1'b0;
		in_valid = 1'b0;
		in_data = '0;
		out_ready = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		arst_n <= 1'b1;

		check_reset();
		send_corners();
		stream_random(NUM_STREAM);
		stall_random(NUM_STALL);
		check_capacity();
		idle_cycles(4);

		if (n_in == n_out && expected_q.size() == 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			stop_with_error($sformatf("Took %0d requests but returned %0d products", n_in, n_out));
		end
	end

endmodule
